//--- design/calc_pkg.sv
package calc_pkg;

    // Widths used across the calculator
    typedef logic [15:0] operand_t;                 // Operand or result, unsigned mod 2^16
    typedef logic [3:0]  digit_t;                   // One keypad digit, 0 to 9
    typedef logic [2:0]  op_code_t;                 // One-hot operator code

    // Operator encodings, one-hot
    localparam op_code_t OP_ADD = 3'b001;           // Addition
    localparam op_code_t OP_SUB = 3'b010;           // Subtraction, wraps below zero
    localparam op_code_t OP_MUL = 3'b100;           // Multiplication, low 16 bits kept

    // Operand pair sent from the controller to both arithmetic units
    typedef struct packed {
        operand_t a;                                // First operand, upper half
        operand_t b;                                // Second operand, lower half
    } operand_pair_t;

    // Number of multiplier bits, one per run cycle
    localparam int unsigned OPERAND_BITS = $bits(operand_t);

    // Digit value zero extended to operand width
    function automatic operand_t digit_to_operand(digit_t digit);
        return operand_t'(digit);
    endfunction

    // Decimal shift in of one digit, x*10 + d built from shifts
    function automatic operand_t shift_in_digit(operand_t value, digit_t digit);
        operand_t times_eight;
        operand_t times_two;
        times_eight = value << 3;
        times_two   = value << 1;
        return times_eight + times_two + digit_to_operand(digit); // Wraps at 16 bits
    endfunction

endpackage

//--- design/gencon.sv
module gencon (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_pkg::digit_t        keypad_input,    // Digit from keypad
    input  logic                    read_input,      // Strobe, one digit per pulse
    input  calc_pkg::op_code_t      operator_input,  // One-hot operator code
    input  logic                    equal_input,     // Starts the calculation
    input  calc_pkg::operand_t      sum,             // From add_sub_unit
    input  logic                    add_done,        // Sum valid this cycle
    input  calc_pkg::operand_t      product,         // From seq_multiplier
    input  logic                    mul_done,        // Product valid this cycle
    output calc_pkg::operand_pair_t operands,        // Held from start until done
    output logic                    subtract,        // Selects a minus b
    output logic                    start_add,       // One-cycle pulse
    output logic                    start_mul,       // One-cycle pulse
    output logic                    complete,        // One-cycle result flag
    output calc_pkg::operand_t      display_output   // Last result, held
);

    // Entry and sequencing states
    typedef enum logic [2:0] {
        GET_FIRST,                                   // Building operand a
        GET_SECOND,                                  // Building operand b
        ISSUE,                                       // Start pulse high
        WAIT,                                        // Waiting for matching done
        SHOW                                         // complete high, result shown
    } state_t;

    state_t                  state, next_state;
    calc_pkg::operand_pair_t opnd_q;                 // Operand accumulators
    calc_pkg::op_code_t      op_q;                   // Operator latched at entry
    logic                    op_valid;               // Operator input is a known code
    logic                    is_mul;                 // Latched op routes to multiplier
    logic                    unit_done;              // Done of the selected unit
    calc_pkg::operand_t      result;                 // Result of the selected unit
    logic                    launch;                 // Equal accepted this cycle
    logic                    finish;                 // Selected unit finished this cycle

    // Only the three one-hot codes count, 011 and friends are dropped
    assign op_valid = (operator_input == calc_pkg::OP_ADD) ||
                      (operator_input == calc_pkg::OP_SUB) ||
                      (operator_input == calc_pkg::OP_MUL);

    assign is_mul    = (op_q == calc_pkg::OP_MUL);
    assign unit_done = is_mul ? mul_done : add_done;  // Other unit is idle anyway
    assign result    = is_mul ? product : sum;
    assign launch    = (state == GET_SECOND) && equal_input;
    assign finish    = (state == WAIT) && unit_done;

    assign operands = opnd_q;                         // Stable outside entry states
    assign subtract = (op_q == calc_pkg::OP_SUB);

    // Next state
    always_comb begin
        next_state = state;                           // Hold by default
        case (state)
            GET_FIRST: begin
                if (op_valid) begin
                    next_state = GET_SECOND;          // Operator ends first operand
                end
            end
            GET_SECOND: begin
                if (equal_input) begin
                    next_state = ISSUE;
                end
            end
            ISSUE: begin
                next_state = WAIT;                    // Start seen by unit at this edge
            end
            WAIT: begin
                if (unit_done) begin
                    next_state = SHOW;
                end
            end
            SHOW: begin
                next_state = GET_FIRST;               // Ready for a fresh calculation
            end
            default: begin
                next_state = GET_FIRST;
            end
        endcase
    end

    // State, operands and outputs
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= GET_FIRST;
            opnd_q         <= '0;
            op_q           <= '0;
            start_add      <= 1'b0;
            start_mul      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state     <= next_state;
            start_add <= launch && !is_mul;           // High during ISSUE
            start_mul <= launch && is_mul;
            complete  <= finish;                      // High during SHOW

            if (finish) begin
                display_output <= result;             // Result only valid with done
            end

            case (state)
                GET_FIRST: begin
                    if (read_input) begin
                        opnd_q.a <= calc_pkg::shift_in_digit(opnd_q.a, keypad_input);
                    end
                    if (op_valid) begin
                        op_q <= operator_input;       // Latched, not read live
                    end
                end
                GET_SECOND: begin
                    if (read_input) begin
                        opnd_q.b <= calc_pkg::shift_in_digit(opnd_q.b, keypad_input);
                    end
                end
                SHOW: begin
                    opnd_q <= '0;                     // Next entry starts from zero
                end
                default: begin
                end
            endcase
        end
    end

    // Units answer only while a result is awaited
    assert property (@(posedge clk) disable iff (!nRST) (add_done || mul_done) |-> state == WAIT);

    // Result flag is a single pulse per calculation
    assert property (@(posedge clk) disable iff (!nRST) complete |=> !complete);

endmodule

//--- design/add_sub_unit.sv
module add_sub_unit (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_pkg::operand_pair_t operands,   // a and b, held until done
    input  logic                    subtract,   // 1 selects a minus b
    input  logic                    start,      // One-cycle pulse
    output calc_pkg::operand_t      sum,        // Valid while add_done high
    output logic                    add_done    // One cycle after start
);

    calc_pkg::operand_t sum_next;               // Combinational result

    // Wraps modulo 2^16 in both directions
    always_comb begin
        if (subtract) begin
            sum_next = operands.a - operands.b;
        end else begin
            sum_next = operands.a + operands.b;
        end
    end

    // Result register, loaded only on start
    always_ff @(posedge clk) begin
        if (start) begin
            sum <= sum_next;
        end
    end

    // Done flag trails start by one cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            add_done <= 1'b0;
        end else begin
            add_done <= start;
        end
    end

    // Controller holds a, b and subtract until done
    assert property (@(posedge clk) disable iff (!nRST)
                     start |=> $stable(operands) && $stable(subtract));

endmodule

//--- design/seq_multiplier.sv
module seq_multiplier (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_pkg::operand_pair_t operands,   // a is multiplicand, b multiplier
    input  logic                    start,      // One-cycle pulse, only when idle
    output calc_pkg::operand_t      product,    // Low 16 bits of a*b
    output logic                    mul_done    // 16 cycles after start
);

    typedef logic [$clog2(calc_pkg::OPERAND_BITS)-1:0] bit_cnt_t;

    typedef enum logic {
        IDLE,                                   // Waiting for start
        RUN                                     // One multiplier bit per cycle
    } state_t;

    state_t             state;
    calc_pkg::operand_t mcand;                  // Multiplicand, shifts left
    calc_pkg::operand_t mplier;                 // Multiplier, shifts right
    calc_pkg::operand_t acc;                    // Partial product, low 16 bits
    calc_pkg::operand_t acc_next;               // Partial product after this bit
    bit_cnt_t           bit_cnt;                // Multiplier bit in progress
    logic               last_bit;               // Final iteration this cycle

    assign last_bit = (bit_cnt == bit_cnt_t'(calc_pkg::OPERAND_BITS - 1));

    // Add shifted multiplicand when current bit is set
    always_comb begin
        acc_next = acc;
        if (mplier[0]) begin
            acc_next = acc + mcand;             // Upper bits fall off
        end
    end

    // Control state
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= RUN;
                        bit_cnt <= '0;
                    end
                end
                RUN: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit) begin
                        state    <= IDLE;
                        mul_done <= 1'b1;       // Product valid with this pulse
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            mcand  <= operands.a;
            mplier <= operands.b;
            acc    <= '0;
        end else if (state == RUN) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
            if (last_bit) begin
                product <= acc_next;
            end
        end
    end

    // Controller never overlaps products
    assert property (@(posedge clk) disable iff (!nRST) start |-> state == IDLE);

endmodule

//--- design/calculator_top.sv
module calculator_top (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::digit_t   keypad_input,    // Digit from keypad
    input  logic               read_input,      // Digit strobe
    input  calc_pkg::op_code_t operator_input,  // One-hot operator
    input  logic               equal_input,     // Start calculation
    output logic               complete,        // One-cycle result flag
    output calc_pkg::operand_t display_output   // Held until next result
);

    calc_pkg::operand_pair_t operands;          // Shared by both units
    calc_pkg::operand_t      sum;
    calc_pkg::operand_t      product;
    logic                    subtract;
    logic                    start_add;
    logic                    start_mul;
    logic                    add_done;
    logic                    mul_done;

    gencon u_gencon (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .sum            (sum),
        .add_done       (add_done),
        .product        (product),
        .mul_done       (mul_done),
        .operands       (operands),
        .subtract       (subtract),
        .start_add      (start_add),
        .start_mul      (start_mul),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit u_add_sub (
        .clk      (clk),
        .nRST     (nRST),
        .operands (operands),
        .subtract (subtract),
        .start    (start_add),
        .sum      (sum),
        .add_done (add_done)
    );

    seq_multiplier u_mul (
        .clk      (clk),
        .nRST     (nRST),
        .operands (operands),
        .start    (start_mul),
        .product  (product),
        .mul_done (mul_done)
    );

endmodule

//--- dv/calc_tb.sv
module calc_tb;

    localparam int MAX_CYCLES = 3000;            // About five times the full test length
    localparam int DONE_BOUND = 40;              // Multiplier needs roughly 20 cycles

    logic                  clk;
    logic                  nRST;
    calc_pkg::digit_t      keypad_input;
    logic                  read_input;
    calc_pkg::op_code_t    operator_input;
    logic                  equal_input;
    logic                  complete;
    calc_pkg::operand_t    display_output;

    int          errors = 0;
    int          calcs = 0;                      // Calculations issued by the tests
    int          complete_count = 0;             // complete pulses seen on the DUT
    int          cycles = 0;
    int unsigned lcg_state = 39265;

    calculator_top dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                   // Period 8
    end

    // Count every result pulse, sampled mid-cycle
    always @(negedge clk) begin
        if (nRST && complete) begin
            complete_count++;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: %0d calculations, %0d errors", calcs, errors + 1);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;                   // Low bits are weak
    endfunction

    // Unsigned modulo 2^16 arithmetic
    function automatic calc_pkg::operand_t expected_result(calc_pkg::operand_t a,
                                                           calc_pkg::operand_t b,
                                                           calc_pkg::op_code_t op);
        logic [31:0] wide;
        case (op)
            calc_pkg::OP_ADD: wide = {16'b0, a} + {16'b0, b};
            calc_pkg::OP_SUB: wide = {16'b0, a} + 32'h10000 - {16'b0, b}; // Wraps below zero
            default:          wide = {16'b0, a} * {16'b0, b};
        endcase
        return wide[15:0];                       // Low 16 bits only
    endfunction

    task automatic check_value(input string name, input calc_pkg::operand_t got,
                               input calc_pkg::operand_t exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic press_digit(input calc_pkg::digit_t digit);
        @(posedge clk);
        keypad_input <= digit;
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;                    // One-cycle strobe
    endtask

    task automatic press_operator(input calc_pkg::op_code_t code);
        @(posedge clk);
        operator_input <= code;
        @(posedge clk);
        operator_input <= '0;
    endtask

    task automatic press_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    // Enters the decimal digits of value and tracks the wrapped operand
    task automatic press_number(input int unsigned value, output calc_pkg::operand_t model);
        int unsigned digs [12];
        int unsigned rest;
        int          n;
        rest  = value;
        n     = 0;
        model = '0;
        do begin
            digs[n] = rest % 10;
            rest    = rest / 10;
            n++;
        end while (rest != 0);
        for (int i = n - 1; i >= 0; i--) begin
            press_digit(calc_pkg::digit_t'(digs[i]));
            model = calc_pkg::operand_t'((32'(model) * 32'd10 + digs[i]) % 32'd65536);
        end
    endtask

    task automatic wait_complete();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!complete && waited < DONE_BOUND) begin
            @(negedge clk);
            waited++;
        end
        if (!complete) begin
            $display("Error at time %0t: no complete pulse within %0d cycles", $time,
                     DONE_BOUND);
            errors++;
        end
    endtask

    // Result check in the complete cycle, then the pulse must drop
    task automatic collect_result(input calc_pkg::operand_t exp);
        wait_complete();
        check_value("display_output", display_output, exp);
        @(negedge clk);
        check_value("complete", 16'(complete), 16'd0);
        calcs++;
    endtask

    task automatic run_calc(input int unsigned x, input calc_pkg::op_code_t op,
                            input int unsigned y);
        calc_pkg::operand_t ma;
        calc_pkg::operand_t mb;
        press_number(x, ma);
        press_operator(op);
        press_number(y, mb);
        press_equal();
        collect_result(expected_result(ma, mb, op));
    endtask

    task automatic test_reset_idle();
        calc_pkg::operand_t mb;
        @(negedge clk);
        check_value("complete", 16'(complete), 16'd0);
        check_value("display_output", display_output, 16'd0);
        press_digit(4);
        press_digit(2);
        repeat (5) @(negedge clk);
        check_value("complete_count", 16'(complete_count), 16'd0); // Digits alone do nothing
        press_operator(calc_pkg::OP_ADD);
        press_number(8, mb);
        press_equal();
        collect_result(expected_result(16'd42, mb, calc_pkg::OP_ADD));
    endtask

    task automatic test_addition();
        run_calc(123, calc_pkg::OP_ADD, 456);
        run_calc(65535, calc_pkg::OP_ADD, 2);    // Wraps past the top
        for (int k = 0; k < 5; k++) begin
            run_calc(next_random() % 100000, calc_pkg::OP_ADD, next_random() % 100000);
        end
    endtask

    task automatic test_subtraction();
        run_calc(5, calc_pkg::OP_SUB, 9);        // 65532 after wrap
        run_calc(900, calc_pkg::OP_SUB, 77);
        run_calc(next_random() % 1000, calc_pkg::OP_SUB, next_random() % 60000);
    endtask

    task automatic test_multiplication();
        run_calc(300, calc_pkg::OP_MUL, 400);    // Product above 65535
        run_calc(255, calc_pkg::OP_MUL, 257);
        run_calc(0, calc_pkg::OP_MUL, 999);
        for (int k = 0; k < 2; k++) begin
            run_calc(next_random() % 5000, calc_pkg::OP_MUL, next_random() % 5000);
        end
    endtask

    task automatic test_entry_rules();
        calc_pkg::operand_t ma;
        calc_pkg::operand_t mb;
        run_calc(1234567, calc_pkg::OP_ADD, 9999999); // Both operands wrap
        press_number(12, ma);
        press_operator(3'b011);                  // Not a valid code
        press_digit(3);                          // Still extends first operand
        press_operator(calc_pkg::OP_ADD);
        press_number(4, mb);
        press_equal();
        collect_result(expected_result(ma * 16'd10 + 16'd3, mb, calc_pkg::OP_ADD));
        press_number(12, ma);
        press_operator(calc_pkg::OP_MUL);
        press_number(300, mb);
        press_equal();
        press_digit(5);                          // Lands while the multiplier runs
        press_digit(6);
        collect_result(expected_result(ma, mb, calc_pkg::OP_MUL));
    endtask

    task automatic test_back_to_back();
        calc_pkg::operand_t ma;
        calc_pkg::operand_t mb;
        run_calc(100, calc_pkg::OP_ADD, 23);
        press_number(7, ma);
        press_operator(calc_pkg::OP_MUL);
        press_number(6, mb);
        @(negedge clk);
        check_value("display_output", display_output, 16'd123); // Old result held
        press_equal();
        collect_result(expected_result(ma, mb, calc_pkg::OP_MUL));
        run_calc(1, calc_pkg::OP_SUB, 1);
    endtask

    initial begin
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        repeat (16) @(posedge clk);
        nRST <= 1'b1;
        test_reset_idle();
        test_addition();
        test_subtraction();
        test_multiplication();
        test_entry_rules();
        test_back_to_back();
        repeat (4) @(negedge clk);
        check_value("complete_count", 16'(complete_count), 16'(calcs)); // No stray pulses
        $display("Done: %0d calculations, %0d errors", calcs, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
design/calc_pkg.sv
design/gencon.sv
design/add_sub_unit.sv
design/seq_multiplier.sv
design/calculator_top.sv
dv/calc_tb.sv

//--- Makefile
TOP := calc_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
